// ==== regx_pkg.sv ====
// regx shared definitions
// register file geometry, lane count and the ALU opcode encoding
`default_nettype none

package regx_pkg;

   //####################################################################
   // register file geometry
   //####################################################################

   localparam int reg_count  = 8;                    // architectural registers
   localparam int reg_width  = 16;                   // register and datapath width
   localparam int reg_addr_w = $clog2(reg_count);    // register address bits

   // two lanes per pair
   // the register file gets two read ports and one write port per lane
   localparam int lane_count = 2;

   //####################################################################
   // opcode encoding
   //####################################################################

   localparam int op_w = 3;

   localparam logic [op_w-1:0] op_add  = 3'd0;   // a + b
   localparam logic [op_w-1:0] op_sub  = 3'd1;   // a - b
   localparam logic [op_w-1:0] op_and  = 3'd2;   // a & b
   localparam logic [op_w-1:0] op_or   = 3'd3;   // a | b
   localparam logic [op_w-1:0] op_xor  = 3'd4;   // a ^ b
   localparam logic [op_w-1:0] op_shl  = 3'd5;   // a << b[3:0]
   localparam logic [op_w-1:0] op_ldi  = 3'd6;   // imm
   localparam logic [op_w-1:0] op_addi = 3'd7;   // a + imm

endpackage : regx_pkg

`default_nettype wire

// ==== regx_alu_lane.sv ====
// regx ALU lane
// combinational, one opcode on two register operands and an immediate
`timescale 1ns/1ps
`default_nettype none

module regx_alu_lane (
   input  wire logic [regx_pkg::op_w-1:0]      op,
   input  wire logic [regx_pkg::reg_width-1:0] a,
   input  wire logic [regx_pkg::reg_width-1:0] b,
   input  wire logic [regx_pkg::reg_width-1:0] imm,
   output logic      [regx_pkg::reg_width-1:0] result
);

   import regx_pkg::*;

   logic [3:0] shamt;   // shift uses low nibble of b only

   assign shamt = b[3:0];

   // all arithmetic wraps at reg_width
   always_comb
   begin
      case (op)
         op_add:  result = a + b;
         op_sub:  result = a - b;
         op_and:  result = a & b;
         op_or:   result = a | b;
         op_xor:  result = a ^ b;
         op_shl:  result = a << shamt;
         op_ldi:  result = imm;        // operands ignored
         op_addi: result = a + imm;
         default: result = '0;         // unreachable, all codes used
      endcase
   end

endmodule : regx_alu_lane

`default_nettype wire

// ==== regx_regfile.sv ====
// regx multi-port register file
// one-hot write enables per register, highest-numbered write port wins,
// AND-OR write data mux, combinational read ports gated by their valid
`timescale 1ns/1ps
`default_nettype none

module regx_regfile #(
   parameter int regs        = regx_pkg::reg_count,       // number of registers
   parameter int width       = regx_pkg::reg_width,       // register width
   parameter int read_ports  = 2 * regx_pkg::lane_count,  // read ports
   parameter int write_ports = regx_pkg::lane_count       // write ports
)(
   input  wire logic                                 clk,
   // write ports, concatenated, port 0 in the low slice
   input  wire logic [write_ports-1:0]               wr_valid,
   input  wire logic [write_ports*$clog2(regs)-1:0]  wr_addr,
   input  wire logic [write_ports*width-1:0]         wr_data,
   // read ports, concatenated
   input  wire logic [read_ports-1:0]                rd_valid,
   input  wire logic [read_ports*$clog2(regs)-1:0]   rd_addr,
   output logic      [read_ports*width-1:0]          rd_data
);

   localparam int addr_w = $clog2(regs);

   logic [width-1:0] mem [regs];   // storage, undefined until written

   //####################################################################
   // write side
   //####################################################################

   for (genvar i = 0; i < regs; i++)
   begin : gen_reg
      logic [write_ports-1:0] hit;     // raw port hits on this register
      logic [write_ports-1:0] sel;     // one-hot after priority masking
      logic [width-1:0]       wdata;   // muxed write word

      for (genvar j = 0; j < write_ports; j++)
      begin : gen_hit
         assign hit[j] = wr_valid[j] & (wr_addr[j*addr_w +: addr_w] == addr_w'(i));
      end

      always_comb
      begin : prio_mux
         logic taken;   // a higher port already claimed this register
         taken = 1'b0;
         sel   = '0;
         wdata = '0;
         // walk down from the top port, first hit masks the rest
         for (int j = write_ports - 1; j >= 0; j--)
         begin
            sel[j] = hit[j] & ~taken;
            taken  = taken | hit[j];
         end
         // and-or mux, sel is one-hot or zero
         for (int j = 0; j < write_ports; j++)
         begin
            wdata = wdata | ({width{sel[j]}} & wr_data[j*width +: width]);
         end
      end

      always_ff @(posedge clk)
      begin
         if (|sel)
         begin
            mem[i] <= wdata;
         end
      end
   end

   //####################################################################
   // read side
   //####################################################################

   for (genvar k = 0; k < read_ports; k++)
   begin : gen_rdport
      // zero when the port is idle
      assign rd_data[k*width +: width] = {width{rd_valid[k]}}
                                       & mem[rd_addr[k*addr_w +: addr_w]];
   end

endmodule : regx_regfile

`default_nettype wire

// ==== regx_issue_ctrl.sv ====
// regx issue controller
// four-phase req/ack slave; reads operands, writes both lanes back and
// holds the two results while ack is high
`timescale 1ns/1ps
`default_nettype none

module regx_issue_ctrl (
   input  wire logic                              clk,
   input  wire logic                              reset,
   // host handshake
   input  wire logic                              req,
   output logic                                   ack,
   // pair fields, stable while req is high
   input  wire logic                              en0,
   input  wire logic                              en1,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   dst0,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   src0_a,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   src0_b,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   dst1,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   src1_a,
   input  wire logic [regx_pkg::reg_addr_w-1:0]   src1_b,
   // register file read side
   output logic      [3:0]                        rd_valid,
   output logic      [4*regx_pkg::reg_addr_w-1:0] rd_addr,
   // lane results
   input  wire logic [regx_pkg::reg_width-1:0]    lane_result0,
   input  wire logic [regx_pkg::reg_width-1:0]    lane_result1,
   // register file write side
   output logic      [1:0]                        wr_valid,
   output logic      [2*regx_pkg::reg_addr_w-1:0] wr_addr,
   output logic      [2*regx_pkg::reg_width-1:0]  wr_data,
   // held results
   output logic      [regx_pkg::reg_width-1:0]    res0,
   output logic      [regx_pkg::reg_width-1:0]    res1
);

   typedef enum logic {st_idle, st_hold} state_t;

   state_t state;
   logic   fire;   // pair executes this cycle

   //####################################################################
   // datapath steering
   //####################################################################

   assign fire = (state == st_idle) & req;

   // port 2k is source a of lane k, 2k+1 is source b
   assign rd_addr  = {src1_b, src1_a, src0_b, src0_a};
   assign rd_valid = {{2{fire & en1}}, {2{fire & en0}}};   // disabled lane reads zero

   // write pulse lasts the single fire cycle
   assign wr_valid = {fire & en1, fire & en0};
   assign wr_addr  = {dst1, dst0};
   assign wr_data  = {lane_result1, lane_result0};

   assign ack = (state == st_hold);

   //####################################################################
   // handshake fsm
   //####################################################################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         res0  <= '0;
         res1  <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (req)
               begin
                  state <= st_hold;                         // ack rises with the write
                  res0  <= en0 ? lane_result0 : '0;
                  res1  <= en1 ? lane_result1 : '0;
               end
            end
            st_hold:
            begin
               if (!req)
               begin
                  state <= st_idle;                         // results stay until next pair
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule : regx_issue_ctrl

`default_nettype wire

// ==== regx_top.sv ====
// regx two-lane register execute unit
// issue controller, 4-read 2-write register file and two ALU lanes
`timescale 1ns/1ps
`default_nettype none

module regx_top (
   input  wire logic                            clk,
   input  wire logic                            reset,
   input  wire logic                            req,
   output logic                                 ack,
   input  wire logic                            en0,
   input  wire logic                            en1,
   input  wire logic [regx_pkg::op_w-1:0]       op0,
   input  wire logic [regx_pkg::op_w-1:0]       op1,
   input  wire logic [regx_pkg::reg_addr_w-1:0] dst0,
   input  wire logic [regx_pkg::reg_addr_w-1:0] src0_a,
   input  wire logic [regx_pkg::reg_addr_w-1:0] src0_b,
   input  wire logic [regx_pkg::reg_addr_w-1:0] dst1,
   input  wire logic [regx_pkg::reg_addr_w-1:0] src1_a,
   input  wire logic [regx_pkg::reg_addr_w-1:0] src1_b,
   input  wire logic [regx_pkg::reg_width-1:0]  imm0,
   input  wire logic [regx_pkg::reg_width-1:0]  imm1,
   output logic      [regx_pkg::reg_width-1:0]  res0,
   output logic      [regx_pkg::reg_width-1:0]  res1
);

   import regx_pkg::*;

   logic [2*lane_count-1:0]            rd_valid;
   logic [2*lane_count*reg_addr_w-1:0] rd_addr;
   logic [2*lane_count*reg_width-1:0]  rd_data;    // a0, b0, a1, b1 from low end
   logic [lane_count-1:0]              wr_valid;
   logic [lane_count*reg_addr_w-1:0]   wr_addr;
   logic [lane_count*reg_width-1:0]    wr_data;
   logic [reg_width-1:0]               lane_result0;
   logic [reg_width-1:0]               lane_result1;

   regx_issue_ctrl i_issue_ctrl (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .ack          (ack),
      .en0          (en0),
      .en1          (en1),
      .dst0         (dst0),
      .src0_a       (src0_a),
      .src0_b       (src0_b),
      .dst1         (dst1),
      .src1_a       (src1_a),
      .src1_b       (src1_b),
      .rd_valid     (rd_valid),
      .rd_addr      (rd_addr),
      .lane_result0 (lane_result0),
      .lane_result1 (lane_result1),
      .wr_valid     (wr_valid),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .res0         (res0),
      .res1         (res1)
   );

   regx_regfile #(
      .regs        (reg_count),
      .width       (reg_width),
      .read_ports  (2 * lane_count),
      .write_ports (lane_count)
   ) i_regfile (
      .clk      (clk),
      .wr_valid (wr_valid),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_valid (rd_valid),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

   // lane 0 on read ports 0 and 1
   regx_alu_lane i_lane0 (
      .op     (op0),
      .a      (rd_data[0*reg_width +: reg_width]),
      .b      (rd_data[1*reg_width +: reg_width]),
      .imm    (imm0),
      .result (lane_result0)
   );

   // lane 1 on read ports 2 and 3
   regx_alu_lane i_lane1 (
      .op     (op1),
      .a      (rd_data[2*reg_width +: reg_width]),
      .b      (rd_data[3*reg_width +: reg_width]),
      .imm    (imm1),
      .result (lane_result1)
   );

endmodule : regx_top

`default_nettype wire

// ==== regx_checker.sv ====
// regx handshake checker
// concurrent assertions on the issue controller's req/ack and write pulse,
// attached to every regx_issue_ctrl through bind
`timescale 1ns/1ps
`default_nettype none

module regx_checker (
   input wire logic       clk,
   input wire logic       reset,
   input wire logic       req,
   input wire logic       ack,
   input wire logic [1:0] wr_valid
);

   // ack only rises on a sampled req
   a_ack_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else $error("ack rose while req was low");

   // ack held until the host lets go
   a_ack_fall: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !$past(req))
      else $error("ack fell while req was high");

   // write pulse is the cycle right before ack
   a_wr_pulse: assert property (@(posedge clk) disable iff (reset)
      (wr_valid != 2'b00) |=> $rose(ack))
      else $error("write valid outside the execute cycle");

   a_reset_quiet: assert property (@(posedge clk)
      reset |=> (!ack && wr_valid == 2'b00))   // checked through reset too
      else $error("ack or write valid active after reset");

endmodule : regx_checker

bind regx_issue_ctrl regx_checker i_checker (
   .clk      (clk),
   .reset    (reset),
   .req      (req),
   .ack      (ack),
   .wr_valid (wr_valid)
);

`default_nettype wire

// ==== regx_tb.sv ====
// regx testbench
// directed pair table, then LFSR pairs, checked against a register model
`timescale 1ns/1ps
`default_nettype none

module regx_tb;

   import regx_pkg::*;

   localparam int timeout_cycles = 64 * 8 + 200;   // 64 pairs at 8 cycles each plus slack

   typedef struct packed {
      logic        en0;
      logic        en1;
      logic [2:0]  op0;
      logic [2:0]  op1;
      logic [2:0]  dst0;
      logic [2:0]  s0a;
      logic [2:0]  s0b;
      logic [2:0]  dst1;
      logic [2:0]  s1a;
      logic [2:0]  s1b;
      logic [15:0] imm0;
      logic [15:0] imm1;
      logic [15:0] exp0;   // expected res0
      logic [15:0] exp1;   // expected res1
   } row_t;

   logic                  clk;
   logic                  reset;
   logic                  req;
   logic                  ack;
   logic                  en0;
   logic                  en1;
   logic [op_w-1:0]       op0;
   logic [op_w-1:0]       op1;
   logic [reg_addr_w-1:0] dst0;
   logic [reg_addr_w-1:0] src0_a;
   logic [reg_addr_w-1:0] src0_b;
   logic [reg_addr_w-1:0] dst1;
   logic [reg_addr_w-1:0] src1_a;
   logic [reg_addr_w-1:0] src1_b;
   logic [reg_width-1:0]  imm0;
   logic [reg_width-1:0]  imm1;
   logic [reg_width-1:0]  res0;
   logic [reg_width-1:0]  res1;

   logic [15:0] model_regs [reg_count];   // reference register file
   logic [15:0] lfsr = 16'd31;
   row_t        rows [$];
   int unsigned cycles = 0;

   regx_top i_regx_top (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .ack    (ack),
      .en0    (en0),
      .en1    (en1),
      .op0    (op0),
      .op1    (op1),
      .dst0   (dst0),
      .src0_a (src0_a),
      .src0_b (src0_b),
      .dst1   (dst1),
      .src1_a (src1_a),
      .src1_b (src1_b),
      .imm0   (imm0),
      .imm1   (imm1),
      .res0   (res0),
      .res1   (res1)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // hang guard
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
      begin
         $display("timeout: a handshake did not complete in time");
         $display("Regression failed");
         $fatal(1, "simulation stopped by cycle limit");
      end
   end

   //####################################################################
   // reference model
   //####################################################################

   function automatic logic [15:0] alu_ref(input logic [2:0] op,
                                           input logic [15:0] a, b, imm);
      case (op)
         op_add:  return a + b;          // wraps at 16 bits
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_shl:  return a << b[3:0];    // low nibble only
         op_ldi:  return imm;
         default: return a + imm;        // addi
      endcase
   endfunction

   // both lanes read old values and lane 1 is written last
   function automatic row_t model_pair(input row_t r);
      row_t o;
      o = r;
      o.exp0 = r.en0 ? alu_ref(r.op0, model_regs[r.s0a], model_regs[r.s0b], r.imm0) : 16'h0;
      o.exp1 = r.en1 ? alu_ref(r.op1, model_regs[r.s1a], model_regs[r.s1b], r.imm1) : 16'h0;
      if (r.en0)
         model_regs[r.dst0] = o.exp0;
      if (r.en1)
         model_regs[r.dst1] = o.exp1;
      return o;
   endfunction

   function automatic void add_row(input int e0, input logic [2:0] o0, input int d0, a0, b0,
                                   input logic [15:0] i0, input int e1,
                                   input logic [2:0] o1, input int d1, a1, b1,
                                   input logic [15:0] i1);
      row_t r;
      r = '0;
      r.en0  = (e0 != 0);
      r.op0  = o0;
      r.dst0 = 3'(d0);
      r.s0a  = 3'(a0);
      r.s0b  = 3'(b0);
      r.imm0 = i0;
      r.en1  = (e1 != 0);
      r.op1  = o1;
      r.dst1 = 3'(d1);
      r.s1a  = 3'(a1);
      r.s1b  = 3'(b1);
      r.imm1 = i1;
      rows.push_back(model_pair(r));
   endfunction

   // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[14:0], fb};
      end
      return v;
   endfunction

   //####################################################################
   // drivers and checks
   //####################################################################

   task automatic check_val(input string name, input logic [15:0] act, input logic [15:0] exp);
      if (act !== exp)
      begin
         $display("ERROR %0t %s: got %h expected %h", $time, name, act, exp);
         $display("Regression failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_ack(input logic level);
      do
      begin
         @(posedge clk);
         #1;                              // sample past the edge
      end
      while (ack !== level);
   endtask

   // one four-phase transfer starting 1 ns after a rising edge
   task automatic run_pair(input row_t r, input int idx);
      en0    = r.en0;
      en1    = r.en1;
      op0    = r.op0;
      op1    = r.op1;
      dst0   = r.dst0;
      src0_a = r.s0a;
      src0_b = r.s0b;
      dst1   = r.dst1;
      src1_a = r.s1a;
      src1_b = r.s1b;
      imm0   = r.imm0;
      imm1   = r.imm1;
      req    = 1'b1;
      wait_ack(1'b1);
      check_val($sformatf("res0 (pair %0d)", idx), res0, r.exp0);
      check_val($sformatf("res1 (pair %0d)", idx), res1, r.exp1);
      req = 1'b0;
      wait_ack(1'b0);                     // fields free again after this
   endtask

   initial
   begin
      row_t r;
      reset = 1'b1;
      req   = 1'b0;
      {en0, en1, op0, op1} = '0;
      {dst0, src0_a, src0_b, dst1, src1_a, src1_b} = '0;
      {imm0, imm1} = '0;

      // load all registers with r0 held at zero
      add_row(1, op_ldi, 0, 0, 0, 16'h0000, 1, op_ldi, 1, 0, 0, 16'h1234);
      add_row(1, op_ldi, 2, 0, 0, 16'hffff, 1, op_ldi, 3, 0, 0, 16'h8000);
      add_row(1, op_ldi, 4, 0, 0, 16'h00f0, 1, op_ldi, 5, 0, 0, 16'h7fff);
      add_row(1, op_ldi, 6, 0, 0, 16'h0003, 1, op_ldi, 7, 0, 0, 16'ha5a5);
      // read back with or against r0
      add_row(1, op_or, 1, 1, 0, 16'h0000, 1, op_or, 2, 2, 0, 16'h0000);
      add_row(1, op_or, 3, 3, 0, 16'h0000, 1, op_or, 4, 4, 0, 16'h0000);
      add_row(1, op_or, 5, 5, 0, 16'h0000, 1, op_or, 6, 6, 0, 16'h0000);
      add_row(1, op_or, 7, 7, 0, 16'h0000, 1, op_or, 0, 0, 0, 16'h0000);
      // every opcode with add and sub wrap
      add_row(1, op_add, 7, 2, 3, 16'h0000, 1, op_sub, 6, 0, 1, 16'h0000);
      add_row(1, op_and, 7, 2, 4, 16'h0000, 1, op_or, 6, 3, 4, 16'h0000);
      add_row(1, op_xor, 7, 1, 2, 16'h0000, 1, op_shl, 6, 1, 5, 16'h0000);
      add_row(1, op_ldi, 7, 0, 0, 16'h0c3c, 1, op_addi, 6, 2, 0, 16'h0002);
      add_row(1, op_shl, 7, 4, 2, 16'h0000, 1, op_addi, 6, 1, 0, 16'h0010);
      // lane 1 sees the old r5 and the next pair sees the new one
      add_row(1, op_ldi, 5, 0, 0, 16'h5555, 1, op_or, 4, 5, 0, 16'h0000);
      add_row(1, op_or, 3, 5, 0, 16'h0000, 1, op_add, 4, 5, 0, 16'h0000);
      // both lanes write r2 and lane 1 is stored
      add_row(1, op_ldi, 2, 0, 0, 16'h1111, 1, op_ldi, 2, 0, 0, 16'h2222);
      add_row(1, op_or, 1, 2, 0, 16'h0000, 1, op_xor, 3, 2, 0, 16'h0000);
      // disabled lanes
      add_row(0, op_ldi, 1, 0, 0, 16'hdead, 1, op_addi, 7, 0, 0, 16'h0042);
      add_row(1, op_or, 6, 1, 0, 16'h0000, 0, op_ldi, 0, 0, 0, 16'hbeef);
      add_row(1, op_or, 5, 0, 0, 16'h0000, 1, op_and, 4, 1, 2, 16'h0000);
      add_row(0, op_add, 3, 1, 2, 16'h0000, 0, op_ldi, 2, 0, 0, 16'hffff);
      add_row(1, op_sub, 3, 0, 2, 16'h0000, 1, op_add, 2, 7, 7, 16'h0000);
      add_row(1, op_xor, 1, 6, 7, 16'h0000, 1, op_shl, 0, 2, 6, 16'h0000);
      add_row(1, op_addi, 5, 5, 0, 16'hffff, 1, op_ldi, 4, 0, 0, 16'h0000);

      repeat (16) @(posedge clk);
      #1 reset = 1'b0;
      repeat (2) @(posedge clk);
      #1;

      // results come out of reset cleared
      check_val("res0", res0, 16'h0000);
      check_val("res1", res1, 16'h0000);

      foreach (rows[i])
         run_pair(rows[i], i);

      // random pairs once every register holds a value
      for (int i = 0; i < 40; i++)
      begin
         r      = '0;
         r.en0  = rand_bits(1) != 16'h0;
         r.en1  = rand_bits(1) != 16'h0;
         r.op0  = 3'(rand_bits(3));
         r.op1  = 3'(rand_bits(3));
         r.dst0 = 3'(rand_bits(3));
         r.s0a  = 3'(rand_bits(3));
         r.s0b  = 3'(rand_bits(3));
         r.dst1 = 3'(rand_bits(3));
         r.s1a  = 3'(rand_bits(3));
         r.s1b  = 3'(rand_bits(3));
         r.imm0 = rand_bits(16);
         r.imm1 = rand_bits(16);
         run_pair(model_pair(r), rows.size() + i);
      end

      $display("Regression passed");
      $finish;
   end

endmodule : regx_tb

`default_nettype wire

// ==== regx.f ====
regx_pkg.sv
regx_alu_lane.sv
regx_regfile.sv
regx_issue_ctrl.sv
regx_top.sv
regx_checker.sv
regx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the regx regression with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module regx_tb -f regx.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vregx_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1
